// File: ao_periph_subsys.f
src/ao_periph_pkg.sv
src/obi_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/fast_intr_ctrl.sv
src/gpio.sv
src/ao_timer.sv
src/ao_periph_subsys.sv
sim/tb_ao_periph_subsys.sv

// File: sim/tb_ao_periph_subsys.sv
/*
 * Testbench for the always-on peripheral subsystem. Random bus traffic,
 * interrupt and timer stimulus, checked against a register model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ao_periph_subsys
  import ao_periph_pkg::*;
();

  logic                   clk_i;
  logic                   rst_n_i;
  obi_req_t               obi_req;
  obi_resp_t              obi_resp;
  logic                   boot_select;
  logic                   exec_flash;
  logic                   exit_valid;
  logic [31:0]            exit_value;
  logic [FAST_INTR_W-1:0] fast_intr_in;
  logic [FAST_INTR_W-1:0] fast_intr_out;
  logic [GPIO_W-1:0]      gpio_in;
  logic [GPIO_W-1:0]      gpio_out;
  logic [GPIO_W-1:0]      gpio_en;
  logic [GPIO_W-1:0]      intr_gpio;
  logic [1:0]             intr_timer;

  integer seed;
  int     checks;
  int     errors;
  int     cycle_cnt;

  // Register model
  logic                   exit_valid_m;
  logic [31:0]            exit_value_m;
  logic [FAST_INTR_W-1:0] fi_en_m;
  logic [GPIO_W-1:0]      gpio_out_m;
  logic [GPIO_W-1:0]      gpio_dir_m;
  logic [GPIO_W-1:0]      gpio_ien_m;
  logic                   tmr_en_m;
  logic [31:0]            tmr_presc_m;
  logic [1:0][31:0]       cmp_m;

  ao_periph_subsys ao_periph_subsys_i (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .obi_req_i           (obi_req),
    .obi_resp_o          (obi_resp),
    .boot_select_i       (boot_select),
    .execute_from_flash_i(exec_flash),
    .exit_valid_o        (exit_valid),
    .exit_value_o        (exit_value),
    .fast_intr_i         (fast_intr_in),
    .fast_intr_o         (fast_intr_out),
    .gpio_i              (gpio_in),
    .gpio_o              (gpio_out),
    .gpio_en_o           (gpio_en),
    .intr_gpio_o         (intr_gpio),
    .intr_timer_o        (intr_timer)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    #(3000 * 100);
    $display("Watchdog timeout: the run did not finish within 3000 clocks");
    $display("Checks failed");
    $finish;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0d ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("ERROR %0d ns: %s", $time, msg);
      errors++;
    end
  endtask

  function automatic logic [31:0] reg_addr(input ao_slave_e slv, input logic [7:0] ofs);
    return {22'h0, slv, ofs};
  endfunction

  // Unmapped, misaligned or past the last register of its block
  function automatic bit model_err(input logic [31:0] addr);
    logic [7:0] ofs;
    ofs = addr[7:0];
    if (addr[31:10] != 0 || addr[1:0] != 0) return 1'b1;
    case (addr[9:8])
      SLV_SOC_CTRL:  return ofs > EXEC_FLASH;
      SLV_FAST_INTR: return ofs > FI_ENABLE;
      SLV_GPIO:      return ofs > GPIO_INTR_STATUS;
      default:       return ofs > TMR_CMP1;
    endcase
  endfunction

  // Registers whose value the model can predict at any time
  function automatic logic [31:0] shadow_read(input logic [31:0] addr, output bit stable);
    logic [9:0] key;
    key    = addr[9:0];
    stable = 1'b1;
    case (key)
      {SLV_SOC_CTRL, EXIT_VALID}:   return {31'h0, exit_valid_m};
      {SLV_SOC_CTRL, EXIT_VALUE}:   return exit_value_m;
      {SLV_SOC_CTRL, BOOT_SELECT}:  return {31'h0, boot_select};
      {SLV_SOC_CTRL, EXEC_FLASH}:   return {31'h0, exec_flash};
      {SLV_FAST_INTR, FI_CLEAR}:    return 32'h0;
      {SLV_FAST_INTR, FI_ENABLE}:   return 32'(fi_en_m);
      {SLV_GPIO, GPIO_OUT}:         return 32'(gpio_out_m);
      {SLV_GPIO, GPIO_DIR}:         return 32'(gpio_dir_m);
      {SLV_GPIO, GPIO_INTR_EN}:     return 32'(gpio_ien_m);
      {SLV_TIMER, TMR_CTRL}:        return {31'h0, tmr_en_m};
      {SLV_TIMER, TMR_PRESCALE}:    return tmr_presc_m;
      {SLV_TIMER, TMR_CMP0}:        return cmp_m[0];
      {SLV_TIMER, TMR_CMP1}:        return cmp_m[1];
      default: begin
        stable = 1'b0;
        return 32'h0;
      end
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
    logic [9:0] key;
    key = addr[9:0];
    if (!model_err(addr)) begin
      case (key)
        {SLV_SOC_CTRL, EXIT_VALID}: exit_valid_m = data[0];
        {SLV_SOC_CTRL, EXIT_VALUE}: exit_value_m = data;
        {SLV_FAST_INTR, FI_ENABLE}: fi_en_m = data[FAST_INTR_W-1:0];
        {SLV_GPIO, GPIO_OUT}:       gpio_out_m = data[GPIO_W-1:0];
        {SLV_GPIO, GPIO_DIR}:       gpio_dir_m = data[GPIO_W-1:0];
        {SLV_GPIO, GPIO_INTR_EN}:   gpio_ien_m = data[GPIO_W-1:0];
        {SLV_TIMER, TMR_CTRL}:      tmr_en_m = data[0];
        {SLV_TIMER, TMR_PRESCALE}:  tmr_presc_m = data;
        {SLV_TIMER, TMR_CMP0}:      cmp_m[0] = data;
        {SLV_TIMER, TMR_CMP1}:      cmp_m[1] = data;
        default: ;
      endcase
    end
  endtask

  // Called on a falling edge, returns on the falling edge of the response
  task automatic bus_access(input bit we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    #1;
    check_true(obi_resp.gnt === 1'b1, "gnt was not given in the request cycle");
    @(negedge clk_i);
    check_true(obi_resp.rvalid === 1'b1, "rvalid did not follow the grant by one cycle");
    check_eq("obi_resp.err", 32'(obi_resp.err), 32'h0);
    rdata       = obi_resp.rdata;
    obi_req.req = 1'b0;
    model_write_if(we, addr, wdata);
  endtask

  task automatic model_write_if(input bit we, input logic [31:0] addr, input logic [31:0] data);
    if (we) model_write(addr, data);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    bus_access(1'b1, addr, data, rdata);
    check_eq("obi_resp.rdata", rdata, 32'h0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic read_check(input logic [31:0] addr, input string name);
    logic [31:0] data;
    logic [31:0] exp;
    bit          stable;
    bus_read(addr, data);
    exp = shadow_read(addr, stable);
    check_eq(name, data, exp);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset_rw();
    int err_before;
    err_before = errors;
    check_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    check_eq("gpio_o", 32'(gpio_out), 32'h0);
    check_eq("gpio_en_o", 32'(gpio_en), 32'h0);
    check_eq("intr_gpio_o", 32'(intr_gpio), 32'h0);
    check_eq("fast_intr_o", 32'(fast_intr_out), 32'h0);
    check_eq("intr_timer_o", 32'(intr_timer), 32'h0);
    check_eq("obi_resp.rvalid", 32'(obi_resp.rvalid), 32'h0);
    bus_write(reg_addr(SLV_SOC_CTRL, EXIT_VALID), 32'h1);
    bus_write(reg_addr(SLV_SOC_CTRL, EXIT_VALUE), $random(seed));
    bus_write(reg_addr(SLV_GPIO, GPIO_OUT), $random(seed));
    bus_write(reg_addr(SLV_GPIO, GPIO_DIR), $random(seed));
    bus_write(reg_addr(SLV_FAST_INTR, FI_ENABLE), $random(seed));
    read_check(reg_addr(SLV_SOC_CTRL, EXIT_VALID), "EXIT_VALID");
    read_check(reg_addr(SLV_SOC_CTRL, EXIT_VALUE), "EXIT_VALUE");
    read_check(reg_addr(SLV_GPIO, GPIO_OUT), "GPIO_OUT");
    read_check(reg_addr(SLV_GPIO, GPIO_DIR), "GPIO_DIR");
    read_check(reg_addr(SLV_FAST_INTR, FI_ENABLE), "FI_ENABLE");
    read_check(reg_addr(SLV_SOC_CTRL, BOOT_SELECT), "BOOT_SELECT");
    read_check(reg_addr(SLV_SOC_CTRL, EXEC_FLASH), "EXEC_FLASH");
    check_eq("exit_valid_o", 32'(exit_valid), 32'(exit_valid_m));
    check_eq("exit_value_o", exit_value, exit_value_m);
    check_eq("gpio_o", 32'(gpio_out), 32'(gpio_out_m));
    check_eq("gpio_en_o", 32'(gpio_en), 32'(gpio_dir_m));
    report_test("Test 1 reset and read/write", err_before);
  endtask

  task automatic random_access(output bit we, output logic [31:0] addr, output logic [31:0] wdata);
    logic [31:0] r;
    logic [31:0] s;
    int          idx;
    r     = $random(seed);
    s     = $random(seed);
    wdata = $random(seed);
    we    = r[31];
    addr  = {22'h0, r[9:8], (s[7:0] % 8'd6) * 8'd4};
    case (r[2:0])
      3'd5: addr[1:0] = (s[9:8] == 2'b00) ? 2'b01 : s[9:8];
      3'd6: begin
        idx       = 10 + (s[23:16] % 22);
        addr[idx] = 1'b1;
      end
      3'd7: addr[7:0] = {s[15:10], 2'b00};
      default: ;
    endcase
    // Keep the timer stopped and the GPIO interrupt mask for later tests
    if (addr == reg_addr(SLV_GPIO, GPIO_INTR_EN) || addr == reg_addr(SLV_TIMER, TMR_CTRL) ||
        addr == reg_addr(SLV_TIMER, TMR_MTIME)) begin
      we = 1'b0;
    end
  endtask

  task automatic test_back_to_back();
    int          err_before;
    bit          we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    bit          exp_err;
    bit          check_data;
    bit          stable;
    err_before = errors;
    for (int i = 0; i <= 40; i++) begin
      if (i > 0) begin
        check_true(obi_resp.rvalid === 1'b1, "rvalid missing one cycle after a grant");
        check_eq("obi_resp.err", 32'(obi_resp.err), 32'(exp_err));
        if (check_data) check_eq("obi_resp.rdata", obi_resp.rdata, exp_data);
      end
      if (i < 40) begin
        random_access(we, addr, wdata);
        obi_req.req   = 1'b1;
        obi_req.we    = we;
        obi_req.addr  = addr;
        obi_req.wdata = wdata;
        exp_err  = model_err(addr);
        exp_data = shadow_read(addr, stable);
        if (exp_err || we) exp_data = 32'h0;
        check_data = exp_err || we || stable;
        if (we) model_write(addr, wdata);
        #1;
        check_true(obi_resp.gnt === 1'b1, "gnt was not given to a back-to-back request");
      end else begin
        obi_req.req = 1'b0;
      end
      @(negedge clk_i);
    end
    check_true(obi_resp.rvalid === 1'b0, "rvalid stayed high after the last response");
    report_test("Test 2 back-to-back access and errors", err_before);
  endtask

  task automatic test_fast_intr();
    int                     err_before;
    logic [FAST_INTR_W-1:0] pend_m;
    logic [31:0]            data;
    logic [31:0]            mask;
    err_before = errors;
    bus_write(reg_addr(SLV_FAST_INTR, FI_ENABLE), $random(seed));
    bus_write(reg_addr(SLV_FAST_INTR, FI_CLEAR), 32'h7fff);
    pend_m = '0;
    for (int round = 0; round < 4; round++) begin
      for (int p = 0; p < 6; p++) begin
        fast_intr_in = $random(seed);
        pend_m       = pend_m | fast_intr_in;
        @(negedge clk_i);
        fast_intr_in = '0;
      end
      bus_read(reg_addr(SLV_FAST_INTR, FI_PENDING), data);
      check_eq("FI_PENDING", data, 32'(pend_m));
      mask = $random(seed);
      bus_write(reg_addr(SLV_FAST_INTR, FI_CLEAR), mask);
      pend_m = pend_m & ~mask[FAST_INTR_W-1:0];
      bus_read(reg_addr(SLV_FAST_INTR, FI_PENDING), data);
      check_eq("FI_PENDING after clear", data, 32'(pend_m));
      repeat (2) @(negedge clk_i);
      check_eq("fast_intr_o", 32'(fast_intr_out), 32'(pend_m & fi_en_m));
    end
    report_test("Test 3 fast interrupts", err_before);
  endtask

  task automatic test_gpio();
    int                err_before;
    logic [GPIO_W-1:0] prev_m;
    logic [GPIO_W-1:0] status_m;
    logic [31:0]       data;
    logic [31:0]       mask;
    err_before = errors;
    prev_m     = gpio_in;
    bus_write(reg_addr(SLV_GPIO, GPIO_INTR_EN), $random(seed));
    bus_write(reg_addr(SLV_GPIO, GPIO_INTR_STATUS), 32'hff);
    status_m = '0;
    for (int i = 0; i < 12; i++) begin
      gpio_in  = $random(seed);
      status_m = status_m | (gpio_in & ~prev_m & gpio_ien_m);
      prev_m   = gpio_in;
      repeat (4) @(negedge clk_i);
      bus_read(reg_addr(SLV_GPIO, GPIO_IN), data);
      check_eq("GPIO_IN", data, 32'(gpio_in));
      bus_read(reg_addr(SLV_GPIO, GPIO_INTR_STATUS), data);
      check_eq("GPIO_INTR_STATUS", data, 32'(status_m));
      check_eq("intr_gpio_o", 32'(intr_gpio), 32'(status_m));
      if (i % 4 == 3) begin
        mask = $random(seed);
        bus_write(reg_addr(SLV_GPIO, GPIO_INTR_STATUS), mask);
        status_m = status_m & ~mask[GPIO_W-1:0];
        bus_read(reg_addr(SLV_GPIO, GPIO_INTR_STATUS), data);
        check_eq("GPIO_INTR_STATUS after clear", data, 32'(status_m));
      end
    end
    report_test("Test 4 GPIO interrupts", err_before);
  endtask

  task automatic test_timer();
    int          err_before;
    int          start;
    bit          done;
    logic [31:0] t;
    logic [31:0] t2;
    logic [31:0] r;
    err_before = errors;
    r = $random(seed);
    bus_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'h0);
    bus_write(reg_addr(SLV_TIMER, TMR_MTIME), 32'h0);
    bus_write(reg_addr(SLV_TIMER, TMR_PRESCALE), 32'(r[1:0]));
    bus_write(reg_addr(SLV_TIMER, TMR_CMP0), 32'd5 + 32'(r[15:8] % 8'd36));
    bus_write(reg_addr(SLV_TIMER, TMR_CMP1), 32'd5 + 32'(r[23:16] % 8'd36));
    bus_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'h1);
    start = cycle_cnt;
    done  = 1'b0;
    while (!done) begin
      bus_read(reg_addr(SLV_TIMER, TMR_MTIME), t);
      // Interrupt is registered from mtime, so look one clock later
      @(negedge clk_i);
      check_eq("intr_timer_o", 32'(intr_timer), {30'h0, t >= cmp_m[1], t >= cmp_m[0]});
      if (t >= cmp_m[0] && t >= cmp_m[1]) begin
        done = 1'b1;
      end else if (cycle_cnt - start > 200) begin
        check_true(1'b0, "mtime did not reach both compare values within 200 clocks");
        done = 1'b1;
      end
    end
    bus_write(reg_addr(SLV_TIMER, TMR_CTRL), 32'h0);
    bus_read(reg_addr(SLV_TIMER, TMR_MTIME), t);
    // Longer than the slowest prescaler period
    repeat (4) @(negedge clk_i);
    bus_read(reg_addr(SLV_TIMER, TMR_MTIME), t2);
    check_eq("TMR_MTIME after disable", t2, t);
    report_test("Test 5 timer", err_before);
  endtask

  initial begin
    logic [31:0] pins;
    seed          = 32'h26e9_d544;
    checks        = 0;
    errors        = 0;
    cycle_cnt     = 0;
    rst_n_i       = 1'b0;
    obi_req       = '0;
    fast_intr_in  = '0;
    gpio_in       = '0;
    pins          = $random(seed);
    boot_select   = pins[0];
    exec_flash    = pins[1];
    exit_valid_m  = 1'b0;
    exit_value_m  = 32'h0;
    fi_en_m       = '0;
    gpio_out_m    = '0;
    gpio_dir_m    = '0;
    gpio_ien_m    = '0;
    tmr_en_m      = 1'b0;
    tmr_presc_m   = 32'h0;
    cmp_m         = '1;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    test_reset_rw();
    test_back_to_back();
    test_fast_intr();
    test_gpio();
    test_timer();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_ao_periph_subsys

`default_nettype wire

// File: src/ao_periph_subsys.sv
/*
 * Always-on peripheral subsystem top. Bus bridge, register demux and
 * the four always-on slaves
 */
`timescale 1ns/1ps
`default_nettype none

module ao_periph_subsys
  import ao_periph_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,

  input  obi_req_t                    obi_req_i,
  output obi_resp_t                   obi_resp_o,

  input  wire logic                   boot_select_i,
  input  wire logic                   execute_from_flash_i,
  output logic                        exit_valid_o,
  output logic      [31:0]            exit_value_o,

  input  wire logic [FAST_INTR_W-1:0] fast_intr_i,
  output logic      [FAST_INTR_W-1:0] fast_intr_o,

  input  wire logic [GPIO_W-1:0]      gpio_i,
  output logic      [GPIO_W-1:0]      gpio_o,
  output logic      [GPIO_W-1:0]      gpio_en_o,
  output logic      [GPIO_W-1:0]      intr_gpio_o,

  output logic      [1:0]             intr_timer_o
);

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [NUM_SLAVES-1:0] slv_req;
  reg_rsp_t [NUM_SLAVES-1:0] slv_rsp;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_resp_o,
    .reg_req_o(periph_req),
    .reg_rsp_i(periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i(periph_req),
    .reg_rsp_o(periph_rsp),
    .slv_req_o(slv_req),
    .slv_rsp_i(slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[SLV_SOC_CTRL]),
    .reg_rsp_o(slv_rsp[SLV_SOC_CTRL]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[SLV_FAST_INTR]),
    .reg_rsp_o(slv_rsp[SLV_FAST_INTR]),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio gpio_i_ao (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[SLV_GPIO]),
    .reg_rsp_o(slv_rsp[SLV_GPIO]),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_gpio_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[SLV_TIMER]),
    .reg_rsp_o(slv_rsp[SLV_TIMER]),
    .intr_timer_o
  );

endmodule : ao_periph_subsys

`default_nettype wire

// File: src/ao_timer.sv
/*
 * Machine timer. Prescaled 32-bit mtime with two level compare interrupts
 */
`timescale 1ns/1ps
`default_nettype none

module ao_timer
  import ao_periph_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,

  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,

  output logic [1:0] intr_timer_o
);

  logic [7:0]       ofs;
  logic             wr;
  logic             en_q;
  logic             tick;
  logic [31:0]      prescale_q;
  logic [31:0]      presc_cnt_q;
  logic [31:0]      mtime_q;
  logic [1:0][31:0] cmp_q;

  assign ofs  = reg_req_i.addr[ADDR_OFS_MSB:0];
  assign wr   = reg_req_i.valid & reg_req_i.write;
  // One tick every prescale+1 clocks
  assign tick = en_q & (presc_cnt_q >= prescale_q);

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      TMR_CTRL:     reg_rsp_o.rdata = {31'h0, en_q};
      TMR_PRESCALE: reg_rsp_o.rdata = prescale_q;
      TMR_MTIME:    reg_rsp_o.rdata = mtime_q;
      TMR_CMP0:     reg_rsp_o.rdata = cmp_q[0];
      TMR_CMP1:     reg_rsp_o.rdata = cmp_q[1];
      default:      reg_rsp_o.error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q         <= 1'b0;
      prescale_q   <= 32'h0;
      presc_cnt_q  <= 32'h0;
      mtime_q      <= 32'h0;
      cmp_q        <= '1;
      intr_timer_o <= 2'b00;
    end else begin
      presc_cnt_q <= (!en_q || tick) ? 32'h0 : presc_cnt_q + 32'd1;
      if (wr && ofs == TMR_MTIME) begin
        mtime_q <= reg_req_i.wdata;
      end else if (tick) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr && ofs == TMR_CTRL)     en_q       <= reg_req_i.wdata[0];
      if (wr && ofs == TMR_PRESCALE) prescale_q <= reg_req_i.wdata;
      if (wr && ofs == TMR_CMP0)     cmp_q[0]   <= reg_req_i.wdata;
      if (wr && ofs == TMR_CMP1)     cmp_q[1]   <= reg_req_i.wdata;
      for (int i = 0; i < 2; i++) begin
        intr_timer_o[i] <= (mtime_q >= cmp_q[i]);
      end
    end
  end

endmodule : ao_timer

`default_nettype wire

// File: src/gpio.sv
/*
 * 8-bit GPIO with synchronized inputs, output and direction registers
 * and sticky rising-edge interrupts
 */
`timescale 1ns/1ps
`default_nettype none

module gpio
  import ao_periph_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,

  input  reg_req_t               reg_req_i,
  output reg_rsp_t               reg_rsp_o,

  input  wire logic [GPIO_W-1:0] gpio_i,
  output logic      [GPIO_W-1:0] gpio_o,
  output logic      [GPIO_W-1:0] gpio_en_o,
  output logic      [GPIO_W-1:0] intr_gpio_o
);

  logic [7:0]        ofs;
  logic              wr;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] clr_mask;

  assign ofs      = reg_req_i.addr[ADDR_OFS_MSB:0];
  assign wr       = reg_req_i.valid & reg_req_i.write;
  assign rise     = sync2_q & ~prev_q & intr_en_q;
  assign clr_mask = (wr && ofs == GPIO_INTR_STATUS) ? reg_req_i.wdata[GPIO_W-1:0] : '0;

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      GPIO_IN:          reg_rsp_o.rdata = 32'(sync2_q);
      GPIO_OUT:         reg_rsp_o.rdata = 32'(gpio_o);
      GPIO_DIR:         reg_rsp_o.rdata = 32'(gpio_en_o);
      GPIO_INTR_EN:     reg_rsp_o.rdata = 32'(intr_en_q);
      GPIO_INTR_STATUS: reg_rsp_o.rdata = 32'(intr_gpio_o);
      default:          reg_rsp_o.error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q     <= '0;
      sync2_q     <= '0;
      prev_q      <= '0;
      gpio_o      <= '0;
      gpio_en_o   <= '0;
      intr_en_q   <= '0;
      intr_gpio_o <= '0;
    end else begin
      sync1_q     <= gpio_i;
      sync2_q     <= sync1_q;
      prev_q      <= sync2_q;
      // New edge wins over a clear in the same cycle
      intr_gpio_o <= (intr_gpio_o & ~clr_mask) | rise;
      if (wr && ofs == GPIO_OUT)     gpio_o    <= reg_req_i.wdata[GPIO_W-1:0];
      if (wr && ofs == GPIO_DIR)     gpio_en_o <= reg_req_i.wdata[GPIO_W-1:0];
      if (wr && ofs == GPIO_INTR_EN) intr_en_q <= reg_req_i.wdata[GPIO_W-1:0];
    end
  end

endmodule : gpio

`default_nettype wire

// File: src/fast_intr_ctrl.sv
/*
 * Fast interrupt controller. Sticky pending bits, write-one-to-clear
 * and a registered enable mask on the outputs
 */
`timescale 1ns/1ps
`default_nettype none

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,

  input  reg_req_t                    reg_req_i,
  output reg_rsp_t                    reg_rsp_o,

  input  wire logic [FAST_INTR_W-1:0] fast_intr_i,
  output logic      [FAST_INTR_W-1:0] fast_intr_o
);

  logic [7:0]             ofs;
  logic                   wr;
  logic [FAST_INTR_W-1:0] pending_q;
  logic [FAST_INTR_W-1:0] enable_q;
  logic [FAST_INTR_W-1:0] clr_mask;

  assign ofs      = reg_req_i.addr[ADDR_OFS_MSB:0];
  assign wr       = reg_req_i.valid & reg_req_i.write;
  assign clr_mask = (wr && ofs == FI_CLEAR) ? reg_req_i.wdata[FAST_INTR_W-1:0] : '0;

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      FI_PENDING: reg_rsp_o.rdata = 32'(pending_q);
      FI_CLEAR:   reg_rsp_o.rdata = 32'h0;
      FI_ENABLE:  reg_rsp_o.rdata = 32'(enable_q);
      default:    reg_rsp_o.error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q   <= '0;
      enable_q    <= '0;
      fast_intr_o <= '0;
    end else begin
      // Clear wins, a line still high sets again next clock
      pending_q   <= (pending_q | fast_intr_i) & ~clr_mask;
      fast_intr_o <= pending_q & enable_q;
      if (wr && ofs == FI_ENABLE) begin
        enable_q <= reg_req_i.wdata[FAST_INTR_W-1:0];
      end
    end
  end

endmodule : fast_intr_ctrl

`default_nettype wire

// File: src/soc_ctrl.sv
/*
 * SoC control block. Program exit registers and read-only boot status
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  input  reg_req_t         reg_req_i,
  output reg_rsp_t         reg_rsp_o,

  input  wire logic        boot_select_i,
  input  wire logic        execute_from_flash_i,
  output logic             exit_valid_o,
  output logic [31:0]      exit_value_o
);

  logic [7:0] ofs;
  logic       wr;

  assign ofs = reg_req_i.addr[ADDR_OFS_MSB:0];
  assign wr  = reg_req_i.valid & reg_req_i.write;

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      EXIT_VALID:  reg_rsp_o.rdata = {31'h0, exit_valid_o};
      EXIT_VALUE:  reg_rsp_o.rdata = exit_value_o;
      BOOT_SELECT: reg_rsp_o.rdata = {31'h0, boot_select_i};
      EXEC_FLASH:  reg_rsp_o.rdata = {31'h0, execute_from_flash_i};
      default:     reg_rsp_o.error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= 32'h0;
    end else if (wr) begin
      case (ofs)
        EXIT_VALID: exit_valid_o <= reg_req_i.wdata[0];
        EXIT_VALUE: exit_value_o <= reg_req_i.wdata;
        default:    ;
      endcase
    end
  end

endmodule : soc_ctrl

`default_nettype wire

// File: src/reg_demux.sv
/*
 * Register bus decoder and demultiplexer. Routes each access to one slave
 * and answers unmapped space with an error
 */
`timescale 1ns/1ps
`default_nettype none

module reg_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t                  reg_req_i,
  output reg_rsp_t                  reg_rsp_o,

  output reg_req_t [NUM_SLAVES-1:0] slv_req_o,
  input  reg_rsp_t [NUM_SLAVES-1:0] slv_rsp_i
);

  ao_slave_e sel;
  logic      mapped;

  assign sel = ao_slave_e'(reg_req_i.addr[ADDR_SEL_MSB:ADDR_SEL_LSB]);

  // Upper bits clear and word aligned
  assign mapped = ~|reg_req_i.addr[31:ADDR_UNMAP_LSB] &
                  ~|reg_req_i.addr[ADDR_ALIGN_MSB:0];

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      slv_req_o[i]       = reg_req_i;
      slv_req_o[i].addr  = {24'h0, reg_req_i.addr[ADDR_OFS_MSB:0]};
      slv_req_o[i].valid = reg_req_i.valid & mapped & (int'(sel) == i);
    end
  end

  always_comb begin
    if (mapped) begin
      reg_rsp_o = slv_rsp_i[sel];
    end else begin
      reg_rsp_o.rdata = 32'h0;
      reg_rsp_o.error = 1'b1;
    end
  end

endmodule : reg_demux

`default_nettype wire

// File: src/obi_to_reg.sv
/*
 * Bridge from the processor request/grant/valid bus to the register bus.
 * Grants at once and answers one cycle after the grant
 */
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg
  import ao_periph_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_n_i,

  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,

  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        valid_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  // Never stalls
  assign obi_resp_o.gnt = obi_req_i.req;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= obi_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      write_q <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
  end

  assign reg_req_o.valid = valid_q;
  assign reg_req_o.write = write_q;
  assign reg_req_o.addr  = addr_q;
  assign reg_req_o.wdata = wdata_q;

  // Slave answers in the same cycle, so the response goes straight out
  assign obi_resp_o.rvalid = valid_q;
  assign obi_resp_o.err    = valid_q & reg_rsp_i.error;
  assign obi_resp_o.rdata  = (valid_q && !write_q) ? reg_rsp_i.rdata : 32'h0;

endmodule : obi_to_reg

`default_nettype wire

// File: src/ao_periph_pkg.sv
/*
 * Always-on peripheral subsystem package. Bus structs, address map,
 * register offsets and the slave index
 */
`default_nettype none

package ao_periph_pkg;

  // Processor side request/grant/valid bus
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // Register bus, full address until the demux strips it to an offset
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    SLV_SOC_CTRL  = 2'd0,
    SLV_FAST_INTR = 2'd1,
    SLV_GPIO      = 2'd2,
    SLV_TIMER     = 2'd3
  } ao_slave_e;

  localparam int NUM_SLAVES  = 4;
  localparam int FAST_INTR_W = 15;
  localparam int GPIO_W      = 8;

  // Address map
  localparam int ADDR_UNMAP_LSB = 10;
  localparam int ADDR_SEL_MSB   = 9;
  localparam int ADDR_SEL_LSB   = 8;
  localparam int ADDR_OFS_MSB   = 7;
  localparam int ADDR_ALIGN_MSB = 1;

  // SoC control
  localparam logic [7:0] EXIT_VALID  = 8'h00;
  localparam logic [7:0] EXIT_VALUE  = 8'h04;
  localparam logic [7:0] BOOT_SELECT = 8'h08;
  localparam logic [7:0] EXEC_FLASH  = 8'h0C;

  // Fast interrupt controller
  localparam logic [7:0] FI_PENDING = 8'h00;
  localparam logic [7:0] FI_CLEAR   = 8'h04;
  localparam logic [7:0] FI_ENABLE  = 8'h08;

  // GPIO
  localparam logic [7:0] GPIO_IN          = 8'h00;
  localparam logic [7:0] GPIO_OUT         = 8'h04;
  localparam logic [7:0] GPIO_DIR         = 8'h08;
  localparam logic [7:0] GPIO_INTR_EN     = 8'h0C;
  localparam logic [7:0] GPIO_INTR_STATUS = 8'h10;

  // Timer
  localparam logic [7:0] TMR_CTRL     = 8'h00;
  localparam logic [7:0] TMR_PRESCALE = 8'h04;
  localparam logic [7:0] TMR_MTIME    = 8'h08;
  localparam logic [7:0] TMR_CMP0     = 8'h0C;
  localparam logic [7:0] TMR_CMP1     = 8'h10;

endpackage : ao_periph_pkg

`default_nettype wire
